/* common/rvDecode_settings.svh */
`ifndef RVDECODE_SETTINGS_SVH
`define RVDECODE_SETTINGS_SVH

// datapath widths
`define RV_XLEN     64
`define RV_ILEN     32
`define RV_REGIDX_W 5

// major opcodes, instr[6:2]
`define OPC_LOAD    5'b00000
`define OPC_OPIMM   5'b00100
`define OPC_AUIPC   5'b00101
`define OPC_OPIMM32 5'b00110
`define OPC_STORE   5'b01000
`define OPC_OP      5'b01100
`define OPC_LUI     5'b01101
`define OPC_OP32    5'b01110
`define OPC_BRANCH  5'b11000
`define OPC_JALR    5'b11001
`define OPC_JAL     5'b11011
`define OPC_SYSTEM  5'b11100

`endif

/* common/rvDecode_pkg.sv */
`default_nettype none

`include "rvDecode_settings.svh"

package rvDecodePkg;

    typedef logic [`RV_ILEN-1:0]     instrT;
    typedef logic [`RV_XLEN-1:0]     immT;
    typedef logic [`RV_REGIDX_W-1:0] regIdxT;

    typedef logic [5:0] aluCtlT;  // {mulDiv, word, func[3:0]}
    typedef logic [1:0] aluBSrcT;
    typedef logic [2:0] branchT;
    typedef logic [2:0] memOpT;   // load/store funct3

    // operand b select
    localparam aluBSrcT BSRC_RS2  = 2'd0;
    localparam aluBSrcT BSRC_FOUR = 2'd1;
    localparam aluBSrcT BSRC_IMM  = 2'd2;

    // branch kinds
    localparam branchT BR_NONE = 3'b000;
    localparam branchT BR_JAL  = 3'b001;
    localparam branchT BR_JALR = 3'b010;
    localparam branchT BR_EQ   = 3'b100;
    localparam branchT BR_NE   = 3'b101;
    localparam branchT BR_LT   = 3'b110;
    localparam branchT BR_GE   = 3'b111;

    // alu function codes with a fixed meaning
    localparam logic [3:0] ALU_ADD   = 4'b0000;
    localparam logic [3:0] ALU_CMP_S = 4'b0010;  // signed compare
    localparam logic [3:0] ALU_CMP_U = 4'b0011;  // unsigned compare
    localparam logic [3:0] ALU_LUI   = 4'b1111;  // pass operand b

endpackage

`default_nettype wire

/* common/ctrlBus_if.sv */
`default_nettype none

interface ctrlBus_if import rvDecodePkg::*; ();

    logic    regWr;
    logic    aluASrc;   // 1 selects pc
    aluBSrcT aluBSrc;
    aluCtlT  aluCtl;
    branchT  branch;
    logic    memRd;
    logic    memWr;
    logic    memToReg;
    memOpT   memOp;
    logic    illegal;
    logic    halt;

    modport src (
        output regWr, aluASrc, aluBSrc, aluCtl, branch,
        output memRd, memWr, memToReg, memOp,
        output illegal, halt
    );

    modport dst (
        input regWr, aluASrc, aluBSrc, aluCtl, branch,
        input memRd, memWr, memToReg, memOp,
        input illegal, halt
    );

endinterface

`default_nettype wire

/* decoder/ctrlDecoder.sv */
`default_nettype none

`include "rvDecode_settings.svh"

module ctrlDecoder import rvDecodePkg::*; (
    input  instrT  instr,
    ctrlBus_if.src ctrl
);

    logic [4:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       badField;  // funct3/funct7 not allowed for opcode

    assign opcode = instr[6:2];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // memory width follows funct3 directly
    assign ctrl.memOp = funct3;

    always_comb begin
        ctrl.regWr    = 1'b0;
        ctrl.aluASrc  = 1'b0;
        ctrl.aluBSrc  = BSRC_RS2;
        ctrl.aluCtl   = {2'b00, ALU_ADD};
        ctrl.branch   = BR_NONE;
        ctrl.memRd    = 1'b0;
        ctrl.memWr    = 1'b0;
        ctrl.memToReg = 1'b0;
        ctrl.halt     = 1'b0;
        badField      = 1'b0;

        case (opcode)
            `OPC_LOAD: begin
                ctrl.regWr    = 1'b1;
                ctrl.aluBSrc  = BSRC_IMM;
                ctrl.memRd    = 1'b1;
                ctrl.memToReg = 1'b1;
                badField      = (funct3 == 3'b111);  // no ldu
            end

            `OPC_STORE: begin
                ctrl.aluBSrc = BSRC_IMM;
                ctrl.memWr   = 1'b1;
                badField     = funct3[2];  // sb..sd only
            end

            `OPC_OPIMM: begin
                ctrl.regWr   = 1'b1;
                ctrl.aluBSrc = BSRC_IMM;
                ctrl.aluCtl  = {2'b00, funct7[5] && (funct3 == 3'b101), funct3};
                case (funct3)
                    3'b001:  badField = (funct7[6:1] != 6'b000000);
                    3'b101:  badField = (funct7[6:1] != 6'b000000) &&
                                        (funct7[6:1] != 6'b010000);
                    default: badField = 1'b0;  // funct7 is imm here
                endcase
            end

            `OPC_OPIMM32: begin
                ctrl.regWr   = 1'b1;
                ctrl.aluBSrc = BSRC_IMM;
                ctrl.aluCtl  = {2'b01, funct7[5] && (funct3 == 3'b101), funct3};
                case (funct3)
                    3'b000:  badField = 1'b0;  // addiw
                    3'b001:  badField = (funct7 != 7'b0000000);
                    3'b101:  badField = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
                    default: badField = 1'b1;
                endcase
            end

            `OPC_OP, `OPC_OP32: begin
                ctrl.regWr  = 1'b1;
                ctrl.aluCtl = {funct7[0], opcode == `OPC_OP32, funct7[5], funct3};
                case (funct7)
                    7'b0000000: badField = (opcode == `OPC_OP32) &&
                                           !(funct3 inside {3'b000, 3'b001, 3'b101});
                    7'b0100000: badField = (funct3 != 3'b000) && (funct3 != 3'b101);
                    7'b0000001: badField = (opcode == `OPC_OP32) &&
                                           (funct3 inside {3'b001, 3'b010, 3'b011});
                    default:    badField = 1'b1;
                endcase
            end

            `OPC_LUI: begin
                ctrl.regWr   = 1'b1;
                ctrl.aluBSrc = BSRC_IMM;
                ctrl.aluCtl  = {2'b00, ALU_LUI};
            end

            `OPC_AUIPC: begin
                ctrl.regWr   = 1'b1;
                ctrl.aluASrc = 1'b1;
                ctrl.aluBSrc = BSRC_IMM;
            end

            `OPC_JAL: begin
                ctrl.regWr   = 1'b1;
                ctrl.aluASrc = 1'b1;
                ctrl.aluBSrc = BSRC_FOUR;  // link = pc + 4
                ctrl.branch  = BR_JAL;
            end

            `OPC_JALR: begin
                ctrl.regWr   = 1'b1;
                ctrl.aluASrc = 1'b1;
                ctrl.aluBSrc = BSRC_FOUR;
                ctrl.branch  = BR_JALR;
                badField     = (funct3 != 3'b000);
            end

            `OPC_BRANCH: begin
                case (funct3)
                    3'b000: begin
                        ctrl.aluCtl = {2'b00, ALU_CMP_S};
                        ctrl.branch = BR_EQ;
                    end
                    3'b001: begin
                        ctrl.aluCtl = {2'b00, ALU_CMP_S};
                        ctrl.branch = BR_NE;
                    end
                    3'b100: begin
                        ctrl.aluCtl = {2'b00, ALU_CMP_S};
                        ctrl.branch = BR_LT;
                    end
                    3'b101: begin
                        ctrl.aluCtl = {2'b00, ALU_CMP_S};
                        ctrl.branch = BR_GE;
                    end
                    3'b110: begin
                        ctrl.aluCtl = {2'b00, ALU_CMP_U};  // bltu
                        ctrl.branch = BR_LT;
                    end
                    3'b111: begin
                        ctrl.aluCtl = {2'b00, ALU_CMP_U};  // bgeu
                        ctrl.branch = BR_GE;
                    end
                    default: badField = 1'b1;
                endcase
            end

            `OPC_SYSTEM: begin
                ctrl.halt = 1'b1;  // ebreak
            end

            default: badField = 1'b1;  // unknown opcode
        endcase
    end

    // 16-bit encodings are not supported
    assign ctrl.illegal = badField || (instr[1:0] != 2'b11);

endmodule

`default_nettype wire

/* verilog/immGen.sv */
`default_nettype none

`include "rvDecode_settings.svh"

module immGen import rvDecodePkg::*; (
    input  instrT instr,
    output immT   imm
);

    localparam logic [2:0] FMT_I = 3'd0;
    localparam logic [2:0] FMT_S = 3'd1;
    localparam logic [2:0] FMT_B = 3'd2;
    localparam logic [2:0] FMT_U = 3'd3;
    localparam logic [2:0] FMT_J = 3'd4;

    logic [2:0] fmt;
    logic       sign;

    assign sign = instr[31];

    // format from opcode, I covers load/op-imm/jalr/system
    always_comb begin
        case (instr[6:2])
            `OPC_STORE:             fmt = FMT_S;
            `OPC_BRANCH:            fmt = FMT_B;
            `OPC_LUI, `OPC_AUIPC:   fmt = FMT_U;
            `OPC_JAL:               fmt = FMT_J;
            default:                fmt = FMT_I;
        endcase
    end

    always_comb begin
        case (fmt)
            FMT_S: imm = {{(`RV_XLEN-12){sign}}, instr[31:25], instr[11:7]};
            FMT_B: imm = {{(`RV_XLEN-12){sign}}, instr[7], instr[30:25],
                          instr[11:8], 1'b0};
            FMT_U: imm = {{(`RV_XLEN-32){sign}}, instr[31:12], 12'b0};
            FMT_J: imm = {{(`RV_XLEN-20){sign}}, instr[19:12], instr[20],
                          instr[30:21], 1'b0};
            default: imm = {{(`RV_XLEN-12){sign}}, instr[31:20]};  // I
        endcase
    end

endmodule

`default_nettype wire

/* verilog/idPipeReg.sv */
`default_nettype none

module idPipeReg import rvDecodePkg::*; (
    input  logic    clk,
    input  logic    rstN,
    input  logic    instrValid,
    input  instrT   instr,
    input  immT     imm,
    ctrlBus_if.dst  ctrl,
    output logic    outValid,
    output regIdxT  rs1,
    output regIdxT  rs2,
    output regIdxT  rd,
    output immT     immOut,
    output logic    regWr,
    output logic    aluASrc,
    output aluBSrcT aluBSrc,
    output aluCtlT  aluCtl,
    output branchT  branch,
    output logic    memRd,
    output logic    memWr,
    output logic    memToReg,
    output memOpT   memOp,
    output logic    trap,
    output logic    halt
);

    logic keep;  // valid and legal

    assign keep = instrValid && !ctrl.illegal;

    // enables drop on gaps and on illegal instructions
    always_ff @(posedge clk) begin
        if (!rstN) begin
            outValid <= 1'b0;
            regWr    <= 1'b0;
            memRd    <= 1'b0;
            memWr    <= 1'b0;
            branch   <= BR_NONE;
            trap     <= 1'b0;
            halt     <= 1'b0;
        end else begin
            outValid <= instrValid;
            regWr    <= keep && ctrl.regWr;
            memRd    <= keep && ctrl.memRd;
            memWr    <= keep && ctrl.memWr;
            branch   <= keep ? ctrl.branch : BR_NONE;
            trap     <= instrValid && ctrl.illegal;
            halt     <= keep && ctrl.halt;
        end
    end

    // operand fields and selects
    always_ff @(posedge clk) begin
        if (instrValid) begin
            rs1      <= instr[19:15];
            rs2      <= instr[24:20];
            rd       <= instr[11:7];
            immOut   <= imm;
            aluASrc  <= ctrl.aluASrc;
            aluBSrc  <= ctrl.aluBSrc;
            aluCtl   <= ctrl.aluCtl;
            memToReg <= ctrl.memToReg;
            memOp    <= ctrl.memOp;
        end
    end

endmodule

`default_nettype wire

/* verilog/decodeUnit.sv */
`default_nettype none

module decodeUnit import rvDecodePkg::*; (
    input  logic    clk,
    input  logic    rstN,
    input  logic    instrValid,
    input  instrT   instr,
    output logic    outValid,
    output regIdxT  rs1,
    output regIdxT  rs2,
    output regIdxT  rd,
    output immT     imm,
    output logic    regWr,
    output logic    aluASrc,
    output aluBSrcT aluBSrc,
    output aluCtlT  aluCtl,
    output branchT  branch,
    output logic    memRd,
    output logic    memWr,
    output logic    memToReg,
    output memOpT   memOp,
    output logic    trap,
    output logic    halt
);

    ctrlBus_if ctrlBus ();

    immT immRaw;  // unregistered immediate

    ctrlDecoder ctrlDecoder_i (
        .instr (instr),
        .ctrl  (ctrlBus.src)
    );

    immGen immGen_i (
        .instr (instr),
        .imm   (immRaw)
    );

    idPipeReg idPipeReg_i (
        .clk        (clk),
        .rstN       (rstN),
        .instrValid (instrValid),
        .instr      (instr),
        .imm        (immRaw),
        .ctrl       (ctrlBus.dst),
        .outValid   (outValid),
        .rs1        (rs1),
        .rs2        (rs2),
        .rd         (rd),
        .immOut     (imm),
        .regWr      (regWr),
        .aluASrc    (aluASrc),
        .aluBSrc    (aluBSrc),
        .aluCtl     (aluCtl),
        .branch     (branch),
        .memRd      (memRd),
        .memWr      (memWr),
        .memToReg   (memToReg),
        .memOp      (memOp),
        .trap       (trap),
        .halt       (halt)
    );

endmodule

`default_nettype wire

/* testbench/decodeUnit_chk.sv */
`default_nettype none

module decodeUnit_chk (
    input logic clk,
    input logic rstN,
    input logic instrValid,
    input logic outValid,
    input logic trap,
    input logic regWr,
    input logic memWr
);

    int failCount = 0;  // watched by the testbench

    resetClearsValid: assert property (@(posedge clk) !rstN |=> !outValid)
        else begin
            failCount++;
            $error("outValid high in the cycle after reset");
        end

    trapBlocksWrites: assert property (@(posedge clk) disable iff (!rstN)
        trap |-> !regWr && !memWr)
        else begin
            failCount++;
            $error("write enable high together with trap");
        end

    // exactly one cycle of latency
    validFollows: assert property (@(posedge clk) disable iff (!rstN)
        instrValid |=> outValid)
        else begin
            failCount++;
            $error("outValid missing one cycle after instrValid");
        end

    noSpuriousValid: assert property (@(posedge clk) disable iff (!rstN)
        !instrValid |=> !outValid)
        else begin
            failCount++;
            $error("outValid without instrValid one cycle earlier");
        end

endmodule

bind decodeUnit decodeUnit_chk decodeUnit_chk_i (.*);

`default_nettype wire

/* testbench/decodeUnit_tb.sv */
`default_nettype none

`include "rvDecode_settings.svh"

module decodeUnit_tb import rvDecodePkg::*; ();

    localparam int TIMEOUT_CYCLES = 3000;  // roughly twelve times the run length

    logic    clk = 1'b0;
    logic    rstN;
    logic    instrValid;
    instrT   instr;
    logic    outValid;
    regIdxT  rs1;
    regIdxT  rs2;
    regIdxT  rd;
    immT     imm;
    logic    regWr;
    logic    aluASrc;
    aluBSrcT aluBSrc;
    aluCtlT  aluCtl;
    branchT  branch;
    logic    memRd;
    logic    memWr;
    logic    memToReg;
    memOpT   memOp;
    logic    trap;
    logic    halt;

    logic [31:0] rngState = 32'd44;
    int          cycleCnt = 0;

    decodeUnit decodeUnit_i (.*);

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycleCnt <= cycleCnt + 1;
        if (cycleCnt == TIMEOUT_CYCLES)
            stopWithFailure($sformatf("run did not finish within %0d cycles", TIMEOUT_CYCLES));
        else if (decodeUnit_i.decodeUnit_chk_i.failCount != 0)
            stopWithFailure("an assertion in the bound checker failed");
    end

    function logic [31:0] nextRandom();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    function regIdxT pickReg();
        return regIdxT'(nextRandom());
    endfunction

    function automatic instrT rType(input logic [6:0] f7, input regIdxT src2, input regIdxT src1,
                                    input logic [2:0] f3, input regIdxT dst, input logic [4:0] opc);
        return {f7, src2, src1, f3, dst, opc, 2'b11};
    endfunction

    function automatic instrT iType(input logic [11:0] imm12, input regIdxT src1,
                                    input logic [2:0] f3, input regIdxT dst, input logic [4:0] opc);
        return {imm12, src1, f3, dst, opc, 2'b11};
    endfunction

    task automatic stopWithFailure(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic immCheck(input immT got, input immT exp, input string what);
        if (got !== exp)
            stopWithFailure($sformatf("ERR @%0t: %s imm %h, expected %h", $time, what, got, exp));
    endtask

    task automatic aluCtlCheck(input aluCtlT got, input aluCtlT exp, input string what);
        if (got !== exp)
            stopWithFailure($sformatf("ERR @%0t: %s aluCtl %b, expected %b", $time, what, got, exp));
    endtask

    task automatic branchCheck(input branchT got, input branchT exp, input string what);
        if (got !== exp)
            stopWithFailure($sformatf("ERR @%0t: %s branch %b, expected %b", $time, what, got, exp));
    endtask

    task automatic bSrcCheck(input aluBSrcT got, input aluBSrcT exp, input string what);
        if (got !== exp)
            stopWithFailure($sformatf("ERR @%0t: %s aluBSrc %0d, expected %0d", $time, what, got, exp));
    endtask

    task automatic memOpCheck(input memOpT got, input memOpT exp, input string what);
        if (got !== exp)
            stopWithFailure($sformatf("ERR @%0t: %s memOp %0d, expected %0d", $time, what, got, exp));
    endtask

    task automatic regIdxCheck(input regIdxT got, input regIdxT exp, input string what);
        if (got !== exp)
            stopWithFailure($sformatf("ERR @%0t: %s is x%0d, expected x%0d", $time, what, got, exp));
    endtask

    task automatic bitCheck(input logic got, input logic exp, input string what);
        if (got !== exp)
            stopWithFailure($sformatf("ERR @%0t: %s is %b, expected %b", $time, what, got, exp));
    endtask

    // one strobe, outputs sampled mid cycle after the capture edge
    task automatic strobeInstr(input instrT word);
        @(posedge clk);
        instrValid <= 1'b1;
        instr      <= word;
        @(posedge clk);
        instrValid <= 1'b0;
        @(negedge clk);
        bitCheck(outValid, 1'b1, "outValid");
    endtask

    task automatic immediateTests();
        logic [11:0] imm12;
        logic [12:0] imm13;
        logic [19:0] imm20;
        logic [20:0] imm21;
        for (int n = 0; n < 8; n++) begin
            imm12 = 12'(nextRandom());
            strobeInstr(iType(imm12, pickReg(), 3'b000, pickReg(), `OPC_OPIMM));
            immCheck(imm, {{52{imm12[11]}}, imm12}, "addi");
            imm12 = 12'(nextRandom());
            strobeInstr({imm12[11:5], pickReg(), pickReg(), 3'b010, imm12[4:0], `OPC_STORE, 2'b11});
            immCheck(imm, {{52{imm12[11]}}, imm12}, "sw");
            imm13 = {12'(nextRandom()), 1'b0};
            strobeInstr({imm13[12], imm13[10:5], pickReg(), pickReg(), 3'b000, imm13[4:1],
                         imm13[11], `OPC_BRANCH, 2'b11});
            immCheck(imm, {{51{imm13[12]}}, imm13}, "beq");
            imm20 = 20'(nextRandom());
            strobeInstr({imm20, pickReg(), `OPC_LUI, 2'b11});
            immCheck(imm, {{32{imm20[19]}}, imm20, 12'h000}, "lui");
            imm21 = {20'(nextRandom()), 1'b0};
            strobeInstr({imm21[20], imm21[10:1], imm21[11], imm21[19:12], pickReg(), `OPC_JAL, 2'b11});
            immCheck(imm, {{43{imm21[20]}}, imm21}, "jal");
        end
    endtask

    // aluCtl = {mulDiv, word, sub/sra, funct3}
    task automatic aluControlTests();
        logic [2:0] f3;
        logic [2:0] sf3;
        for (int n = 0; n < 8; n++) begin
            f3  = 3'(nextRandom());
            sf3 = nextRandom() & 1 ? 3'b101 : 3'b000;
            strobeInstr(rType(7'b0000000, pickReg(), pickReg(), f3, pickReg(), `OPC_OP));
            aluCtlCheck(aluCtl, {3'b000, f3}, "op");
            bitCheck(trap, 1'b0, "op trap");
            strobeInstr(rType(7'b0000001, pickReg(), pickReg(), f3, pickReg(), `OPC_OP));
            aluCtlCheck(aluCtl, {3'b100, f3}, "mul/div");
            strobeInstr(rType(7'b0100000, pickReg(), pickReg(), sf3, pickReg(), `OPC_OP));
            aluCtlCheck(aluCtl, {3'b001, sf3}, "sub/sra");
            strobeInstr(iType({7'b0000000, 5'(nextRandom())}, pickReg(), f3, pickReg(), `OPC_OPIMM));
            aluCtlCheck(aluCtl, {3'b000, f3}, "op-imm");
            strobeInstr(iType({7'b0100000, 5'(nextRandom())}, pickReg(), 3'b101, pickReg(), `OPC_OPIMM));
            aluCtlCheck(aluCtl, 6'b001101, "srai");
            strobeInstr(rType(7'b0100000, pickReg(), pickReg(), sf3, pickReg(), `OPC_OP32));
            aluCtlCheck(aluCtl, {3'b011, sf3}, "subw/sraw");
            strobeInstr(iType(12'(nextRandom()), pickReg(), 3'b000, pickReg(), `OPC_OPIMM32));
            aluCtlCheck(aluCtl, 6'b010000, "addiw");
        end
    endtask

    task automatic controlFlowTests();
        branchT expBr;
        for (int f = 0; f < 8; f++) begin
            if (f == 2 || f == 3)
                continue;
            case (f)
                0:       expBr = BR_EQ;
                1:       expBr = BR_NE;
                4, 6:    expBr = BR_LT;
                default: expBr = BR_GE;
            endcase
            strobeInstr(rType(7'(nextRandom()), pickReg(), pickReg(), 3'(f), pickReg(), `OPC_BRANCH));
            branchCheck(branch, expBr, "branch");
            aluCtlCheck(aluCtl, (f >= 6) ? 6'b000011 : 6'b000010, "branch compare");
            bitCheck(aluASrc, 1'b0, "branch aluASrc");
            bSrcCheck(aluBSrc, BSRC_RS2, "branch");
            bitCheck(regWr, 1'b0, "branch regWr");
        end
        strobeInstr({20'(nextRandom()), pickReg(), `OPC_JAL, 2'b11});
        branchCheck(branch, BR_JAL, "jal");
        bitCheck(aluASrc, 1'b1, "jal aluASrc");
        bSrcCheck(aluBSrc, BSRC_FOUR, "jal");
        bitCheck(regWr, 1'b1, "jal regWr");
        strobeInstr(iType(12'(nextRandom()), pickReg(), 3'b000, pickReg(), `OPC_JALR));
        branchCheck(branch, BR_JALR, "jalr");
        bitCheck(aluASrc, 1'b1, "jalr aluASrc");
        bSrcCheck(aluBSrc, BSRC_FOUR, "jalr");
        bitCheck(regWr, 1'b1, "jalr regWr");
    endtask

    task automatic memoryTests();
        regIdxT src1;
        regIdxT src2;
        regIdxT dst;
        for (int f = 0; f < 7; f++) begin
            src1 = pickReg();
            dst  = pickReg();
            strobeInstr(iType(12'(nextRandom()), src1, 3'(f), dst, `OPC_LOAD));
            bitCheck(memRd, 1'b1, "load memRd");
            bitCheck(memWr, 1'b0, "load memWr");
            bitCheck(memToReg, 1'b1, "load memToReg");
            bitCheck(regWr, 1'b1, "load regWr");
            memOpCheck(memOp, 3'(f), "load");
            regIdxCheck(rs1, src1, "load rs1");
            regIdxCheck(rd, dst, "load rd");
        end
        for (int f = 0; f < 4; f++) begin
            src1 = pickReg();
            src2 = pickReg();
            strobeInstr(rType(7'(nextRandom()), src2, src1, 3'(f), 5'(nextRandom()), `OPC_STORE));
            bitCheck(memWr, 1'b1, "store memWr");
            bitCheck(memRd, 1'b0, "store memRd");
            bitCheck(memToReg, 1'b0, "store memToReg");
            bitCheck(regWr, 1'b0, "store regWr");
            memOpCheck(memOp, 3'(f), "store");
            regIdxCheck(rs1, src1, "store rs1");
            regIdxCheck(rs2, src2, "store rs2");
        end
    endtask

    task automatic illegalTests();
        instrT bad[5];
        bad[0] = iType(12'(nextRandom()), pickReg(), 3'b111, pickReg(), `OPC_LOAD);
        bad[1] = rType(7'h00, pickReg(), pickReg(), 3'b100, 5'h00, `OPC_STORE);
        bad[2] = rType(7'b0000010, pickReg(), pickReg(), 3'b000, pickReg(), `OPC_OP);
        bad[3] = {25'(nextRandom()), 7'b1111111};  // opcode 11111 unused
        bad[4] = iType(12'(nextRandom()), pickReg(), 3'b000, pickReg(), `OPC_OPIMM);
        bad[4][1:0] = 2'b01;
        foreach (bad[k]) begin
            strobeInstr(bad[k]);
            bitCheck(trap, 1'b1, $sformatf("illegal %0d trap", k));
            bitCheck(regWr, 1'b0, $sformatf("illegal %0d regWr", k));
            bitCheck(memWr, 1'b0, $sformatf("illegal %0d memWr", k));
            bitCheck(memRd, 1'b0, $sformatf("illegal %0d memRd", k));
        end
        strobeInstr(32'h00100073);  // ebreak
        bitCheck(halt, 1'b1, "ebreak halt");
        bitCheck(trap, 1'b0, "ebreak trap");
    endtask

    task automatic throughputTests();
        regIdxT dstA;
        regIdxT srcB;
        dstA = pickReg();
        srcB = pickReg();
        @(posedge clk);
        instrValid <= 1'b1;
        instr      <= iType(12'(nextRandom()), pickReg(), 3'b000, dstA, `OPC_OPIMM);
        @(posedge clk);
        instr      <= rType(7'h00, srcB, pickReg(), 3'b011, 5'h00, `OPC_STORE);
        @(negedge clk);
        bitCheck(outValid, 1'b1, "first outValid");
        regIdxCheck(rd, dstA, "first rd");
        bitCheck(regWr, 1'b1, "first regWr");
        bitCheck(memWr, 1'b0, "first memWr");
        @(posedge clk);
        instrValid <= 1'b0;
        @(negedge clk);
        bitCheck(outValid, 1'b1, "second outValid");
        regIdxCheck(rs2, srcB, "second rs2");
        bitCheck(memWr, 1'b1, "second memWr");
        bitCheck(regWr, 1'b0, "second regWr");
        @(negedge clk);
        bitCheck(outValid, 1'b0, "gap outValid");
        bitCheck(regWr, 1'b0, "gap regWr");
        bitCheck(memWr, 1'b0, "gap memWr");
        bitCheck(memRd, 1'b0, "gap memRd");
    endtask

    initial begin
        rstN       <= 1'b0;
        instrValid <= 1'b0;
        instr      <= '0;
        repeat (10) @(posedge clk);
        rstN <= 1'b1;
        @(negedge clk);
        bitCheck(outValid, 1'b0, "reset outValid");
        bitCheck(regWr, 1'b0, "reset regWr");
        bitCheck(memRd, 1'b0, "reset memRd");
        bitCheck(memWr, 1'b0, "reset memWr");
        bitCheck(trap, 1'b0, "reset trap");
        bitCheck(halt, 1'b0, "reset halt");
        branchCheck(branch, BR_NONE, "reset");
        immediateTests();
        aluControlTests();
        controlFlowTests();
        memoryTests();
        illegalTests();
        throughputTests();
        if (decodeUnit_i.decodeUnit_chk_i.failCount != 0) begin
            stopWithFailure("an assertion in the bound checker failed");
        end else begin
            $display("Test passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* src.f */
+incdir+common
common/rvDecode_pkg.sv
common/ctrlBus_if.sv
decoder/ctrlDecoder.sv
verilog/immGen.sv
verilog/idPipeReg.sv
verilog/decodeUnit.sv
testbench/decodeUnit_chk.sv
testbench/decodeUnit_tb.sv

/* Bender.yml */
package:
  name: rv_decode

sources:
  - include_dirs:
      - common
    files:
      - common/rvDecode_pkg.sv
      - common/ctrlBus_if.sv
      - decoder/ctrlDecoder.sv
      - verilog/immGen.sv
      - verilog/idPipeReg.sv
      - verilog/decodeUnit.sv

  - target: test
    include_dirs:
      - common
    files:
      - testbench/decodeUnit_chk.sv
      - testbench/decodeUnit_tb.sv
